/* tb_vseq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vseq_macros.svh"

module tb_vseq;

  localparam int TIMEOUT = 200;

  logic                                     clk, rst_n;
  vseq_req_pkg::vseq_req_t                  req;
  logic                                     req_valid, req_ready;
  vseq_req_pkg::vseq_resp_t                 resp;
  logic                                     resp_valid, idle;
  vseq_pe_pkg::pe_req_t                     pe_req;
  logic                                     pe_req_valid;
  logic                  [`VSEQ_NR_PES-1:0] pe_ready, stall_mask;
  logic                  [`VSEQ_NR_PES-1:0] rand_ready = '1;
  vseq_pe_pkg::pe_resp_t [`VSEQ_NR_PES-1:0] pe_resp;
  vseq_req_pkg::elen_t                      scalar_resp;
  logic                                     scalar_valid, ack, ack_error;

  // PE model state
  vseq_pe_pkg::vid_mask_t manual_done;
  vseq_pe_pkg::vid_mask_t auto_done = '0;
  vseq_pe_pkg::vid_t      last_taken = '0;
  int unsigned            nr_taken = 0;
  int unsigned            nr_timed = 0;
  int unsigned            timer [`VSEQ_NR_VINSN] = '{default: 0};
  logic                   random_stall, self_retire;
  vseq_pe_pkg::vid_t       id;
  vseq_req_pkg::vseq_req_t r;

  vseq_top UUT (
    .clk_i(clk), .rst_ni(rst_n), .req_i(req), .req_valid_i(req_valid),
    .req_ready_o(req_ready), .resp_o(resp), .resp_valid_o(resp_valid), .idle_o(idle),
    .pe_req_o(pe_req), .pe_req_valid_o(pe_req_valid), .pe_req_ready_i(pe_ready),
    .pe_resp_i(pe_resp), .scalar_resp_i(scalar_resp), .scalar_resp_valid_i(scalar_valid),
    .addrgen_ack_i(ack), .addrgen_error_i(ack_error)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Every PE sees the same done pulses
  assign pe_ready = rand_ready & ~stall_mask;
  always_comb begin
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++)
      pe_resp[pe].vinsn_done = manual_done | auto_done;
  end

  // Broadcast taken by all PEs
  always @(posedge clk) begin
    if (rst_n && pe_req_valid && &pe_ready) begin
      last_taken = pe_req.id;
      nr_taken++;
    end
  end

  always @(negedge clk) begin
    auto_done = '0;
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
      if (timer[i] == 1)
        auto_done[i] = 1'b1;
      if (timer[i] != 0)
        timer[i] = timer[i] - 1;
    end
    // Self-retiring instructions finish a few cycles after the broadcast
    if (nr_taken != nr_timed) begin
      nr_timed = nr_taken;
      if (self_retire)
        timer[last_taken] = 2 + $urandom_range(0, 3);
    end
    rand_ready = '1;
    if (random_stall)
      for (int pe = 0; pe < `VSEQ_NR_PES; pe++)
        rand_ready[pe] = ($urandom_range(0, 3) != 0);
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  // Held broadcast keeps its payload and can only lose hazard bits
  assert property (@(posedge clk) disable iff (!rst_n)
      pe_req_valid && !(&pe_ready) |=> pe_req_valid && pe_req.id == $past(pe_req.id)
      && pe_req.op == $past(pe_req.op) && pe_req.vd == $past(pe_req.vd)
      && (pe_req.hazard_vs1 & ~$past(pe_req.hazard_vs1)) == '0)
    else abort_run("held PE broadcast changed while a PE was not ready");

  assert property (@(posedge clk) disable iff (!rst_n) !(&pe_ready) |-> !req_ready)
    else abort_run("CHECK FAILED req_ready_o got 1 expected 0 while a PE stalls");

  assert property (@(posedge clk) disable iff (!rst_n) resp_valid |-> (ack || scalar_valid))
    else abort_run("response pulse came without an acknowledge or a scalar result");

  // Negative register index means the operand is unused
  function automatic vseq_req_pkg::vseq_req_t make_req(input vseq_req_pkg::vop_e op,
                                                       input int vd, input int vs1,
                                                       input int vs2);
    vseq_req_pkg::vseq_req_t q;
    q    = '0;
    q.op = op;
    q.vm = 1'b1;
    if (vd >= 0) begin
      q.vd     = vseq_req_pkg::vreg_t'(vd);
      q.use_vd = 1'b1;
    end
    if (vs1 >= 0) begin
      q.vs1     = vseq_req_pkg::vreg_t'(vs1);
      q.use_vs1 = 1'b1;
    end
    if (vs2 >= 0) begin
      q.vs2     = vseq_req_pkg::vreg_t'(vs2);
      q.use_vs2 = 1'b1;
    end
    return q;
  endfunction

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic issue_req(input vseq_req_pkg::vseq_req_t rq, output vseq_pe_pkg::vid_t vid);
    int n;
    req       = rq;
    req_valid = 1'b1;
    n         = 0;
    #1;
    while (!req_ready) begin
      n++;
      if (n > TIMEOUT)
        abort_run("request was not accepted within the timeout");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req_valid = 1'b0;
    check_val("pe_req_valid_o", pe_req_valid, 1);
    vid = pe_req.id;
  endtask

  task automatic finish_id(input vseq_pe_pkg::vid_t vid);
    manual_done      = '0;
    manual_done[vid] = 1'b1;
    @(negedge clk);
    manual_done = '0;
  endtask

  task automatic hold_check(input int cycles);
    repeat (cycles) begin
      #1;
      check_val("req_ready_o", req_ready, 0);
      @(negedge clk);
    end
  endtask

  task automatic check_idle();
    #1;
    check_val("idle_o", idle, 1);
    check_val("pe_req_valid_o", pe_req_valid, 0);
    @(negedge clk);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    #1;
    while (!idle) begin
      n++;
      if (n > TIMEOUT)
        abort_run("sequencer did not become idle within the timeout");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
  endtask

  // Load or store holds the dispatcher until the address generator answers
  task automatic release_by_ack(input logic err);
    hold_check(3);
    ack       = 1'b1;
    ack_error = err;
    #1;
    check_val("resp_valid_o", resp_valid, 1);
    check_val("resp_o.error", resp.error, err);
    check_val("req_ready_o", req_ready, 1);
    @(negedge clk);
    ack       = 1'b0;
    ack_error = 1'b0;
    #1;
    check_val("resp_valid_o", resp_valid, 0);
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(2));
    rst_n        = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    stall_mask   = '0;
    manual_done  = '0;
    scalar_resp  = '0;
    scalar_valid = 1'b0;
    ack          = 1'b0;
    ack_error    = 1'b0;
    random_stall = 1'b0;
    self_retire  = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_val("req_ready_o", req_ready, 1);
    check_val("resp_valid_o", resp_valid, 0);
    check_idle();

    // Lowest free ID on every issue
    issue_req(make_req(vseq_req_pkg::VADD, 1, 2, 3), id);
    check_val("pe_req_o.id", id, 0);
    issue_req(make_req(vseq_req_pkg::VMUL, 4, 5, 6), id);
    check_val("pe_req_o.id", id, 1);
    issue_req(make_req(vseq_req_pkg::VADD, 7, 8, 9), id);
    check_val("pe_req_o.id", id, 2);
    finish_id(1);
    issue_req(make_req(vseq_req_pkg::VMUL, 10, 11, 12), id);
    check_val("pe_req_o.id", id, 1);
    finish_id(0);
    finish_id(2);
    finish_id(1);
    check_idle();

    // RAW, then WAR on v1, then WAW on v3
    issue_req(make_req(vseq_req_pkg::VADD, 3, 1, 2), id);
    issue_req(make_req(vseq_req_pkg::VADD, 5, 3, 4), id);
    check_val("pe_req_o.hazard_vs1", pe_req.hazard_vs1, 8'h01);
    issue_req(make_req(vseq_req_pkg::VADD, 1, 6, 7), id);
    check_val("pe_req_o.hazard_vs2", pe_req.hazard_vs2, 8'h01);
    check_val("pe_req_o.hazard_vd", pe_req.hazard_vd, 8'h00);
    issue_req(make_req(vseq_req_pkg::VADD, 3, 8, 9), id);
    check_val("pe_req_o.id", id, 3);
    check_val("pe_req_o.hazard_vd", pe_req.hazard_vd, 8'h01);
    check_val("pe_req_o.vinsn_running", pe_req.vinsn_running, 8'h07);
    for (int i = 0; i < 4; i++)
      finish_id(vseq_pe_pkg::vid_t'(i));
    check_idle();

    // Masked op waits on the writer of v0
    issue_req(make_req(vseq_req_pkg::VADD, 0, 1, 2), id);
    r    = make_req(vseq_req_pkg::VADD, 6, 7, 8);
    r.vm = 1'b0;
    issue_req(r, id);
    check_val("pe_req_o.hazard_vm", pe_req.hazard_vm, 8'h01);
    check_val("pe_req_o.hazard_vs1", pe_req.hazard_vs1, 8'h00);
    finish_id(0);
    finish_id(1);
    check_idle();

    // Lane 1 stalls the dependent broadcast
    issue_req(make_req(vseq_req_pkg::VADD, 3, 1, 2), id);
    issue_req(make_req(vseq_req_pkg::VADD, 5, 3, 4), id);
    stall_mask[1] = 1'b1;
    repeat (3) begin
      #1;
      check_val("req_ready_o", req_ready, 0);
      check_val("pe_req_o.id", pe_req.id, 1);
      check_val("pe_req_o.hazard_vs1", pe_req.hazard_vs1, 8'h01);
      @(negedge clk);
    end
    finish_id(0);
    #1;
    check_val("pe_req_o.hazard_vs1", pe_req.hazard_vs1, 8'h00);
    check_val("pe_req_valid_o", pe_req_valid, 1);
    @(negedge clk);
    stall_mask = '0;
    @(negedge clk);
    #1;
    check_val("pe_req_valid_o", pe_req_valid, 0);
    check_val("last taken id", last_taken, 1);
    @(negedge clk);
    finish_id(1);
    check_idle();

    // Store waits for the mask unit, then for the address generator
    issue_req(make_req(vseq_req_pkg::VMAND, 1, 2, 3), id);
    req       = make_req(vseq_req_pkg::VSE, -1, 4, -1);
    req_valid = 1'b1;
    hold_check(4);
    finish_id(0);
    issue_req(make_req(vseq_req_pkg::VSE, -1, 4, -1), id);
    check_val("pe_req_o.id", id, 0);
    release_by_ack(1'b1);
    finish_id(id);
    check_idle();

    issue_req(make_req(vseq_req_pkg::VLE, 2, -1, -1), id);
    release_by_ack(1'b0);
    finish_id(id);
    check_idle();

    // Scalar move ignores the address generator
    issue_req(make_req(vseq_req_pkg::VMVXS, -1, -1, 2), id);
    hold_check(2);
    ack = 1'b1;
    hold_check(1);
    ack          = 1'b0;
    scalar_resp  = 32'h1234_abcd;
    scalar_valid = 1'b1;
    #1;
    check_val("resp_valid_o", resp_valid, 1);
    check_val("resp_o.resp", resp.resp, 32'h1234_abcd);
    check_val("req_ready_o", req_ready, 1);
    @(negedge clk);
    scalar_valid = 1'b0;
    finish_id(id);
    check_idle();

    // Random PE stalls with self-retiring instructions
    random_stall = 1'b1;
    self_retire  = 1'b1;
    for (int k = 0; k < 12; k++) begin
      r = make_req(($urandom_range(0, 1) == 0) ? vseq_req_pkg::VADD : vseq_req_pkg::VMUL,
                   $urandom_range(1, 31), $urandom_range(1, 31), $urandom_range(1, 31));
      issue_req(r, id);
    end
    random_stall = 1'b0;
    wait_idle();
    self_retire = 1'b0;
    check_idle();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* vinsn_tracker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vseq_macros.svh"

module vinsn_tracker (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Issue from the issue unit
  input  logic                                        issue_i,
  input  vseq_pe_pkg::vid_t                           issue_id_i,
  input  logic                     [`VSEQ_NR_PES-1:0] issue_pes_i,
  // Done pulses from the PEs
  input  vseq_pe_pkg::pe_resp_t    [`VSEQ_NR_PES-1:0] pe_resp_i,
  // Running state
  output vseq_pe_pkg::vid_mask_t                      running_o,
  output vseq_pe_pkg::vid_mask_t                      running_next_o,
  output logic                     [`VSEQ_NR_PES-1:0] pe_busy_o,
  output vseq_pe_pkg::vid_t                           next_id_o,
  output logic                                        full_o,
  output logic                                        idle_o
);

  // One ID bitmap per PE
  vseq_pe_pkg::vid_mask_t [`VSEQ_NR_PES-1:0] pe_running_q, pe_running_d;

  always_comb begin
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      // Done pulses retire the ID on that PE
      pe_running_d[pe] = pe_running_q[pe] & ~pe_resp_i[pe].vinsn_done;
      // New instruction lands on its target PEs
      if (issue_i && issue_pes_i[pe])
        pe_running_d[pe][issue_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      pe_running_q <= '0;
    else
      pe_running_q <= pe_running_d;
  end

  // Global sets, current and as of the next edge
  always_comb begin
    running_o      = '0;
    running_next_o = '0;
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      running_o      |= pe_running_q[pe];
      running_next_o |= pe_running_d[pe];
      pe_busy_o[pe]   = |pe_running_q[pe];
    end
  end

  // Lowest free ID wins, so scan from the top down
  always_comb begin
    next_id_o = '0;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--)
      if (!running_o[i])
        next_id_o = vseq_pe_pkg::vid_t'(i);
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

endmodule

`default_nettype wire

/* vreg_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vseq_macros.svh"

module vreg_scoreboard (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Request at the dispatcher port
  input  vseq_req_pkg::vseq_req_t  req_i,
  input  logic                     issue_i,
  input  vseq_pe_pkg::vid_t        issue_id_i,
  input  vseq_pe_pkg::vid_mask_t   running_i,
  // Hazards for the presented request
  output vseq_pe_pkg::vid_mask_t   hazard_vs_o,
  output vseq_pe_pkg::vid_mask_t   hazard_vd_o,
  output vseq_pe_pkg::vid_mask_t   hazard_vm_o
);

  // Last accessor of a register
  typedef struct packed {
    vseq_pe_pkg::vid_t vid;
    logic              valid;
  } vreg_access_t;

  vreg_access_t [`VSEQ_NR_VREGS-1:0] read_q, read_d, read_live;
  vreg_access_t [`VSEQ_NR_VREGS-1:0] write_q, write_d, write_live;
  vseq_pe_pkg::vid_mask_t            raw_vs, raw_vm, war, waw;

  // Bit of a valid accessor, nothing otherwise
  function automatic vseq_pe_pkg::vid_mask_t id_bit(input vreg_access_t acc);
    id_bit = '0;
    if (acc.valid)
      id_bit[acc.vid] = 1'b1;
  endfunction

  // Entries of IDs that have finished are stale
  always_comb begin
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      read_live[v]        = read_q[v];
      read_live[v].valid  = read_q[v].valid & running_i[read_q[v].vid];
      write_live[v]       = write_q[v];
      write_live[v].valid = write_q[v].valid & running_i[write_q[v].vid];
    end
  end

  always_comb begin
    // RAW on the sources
    raw_vs = '0;
    if (req_i.use_vs1)
      raw_vs |= id_bit(write_live[req_i.vs1]);
    if (req_i.use_vs2)
      raw_vs |= id_bit(write_live[req_i.vs2]);
    // Masked ops also read v0
    raw_vm = req_i.vm ? '0 : id_bit(write_live[`VSEQ_VMASK]);
    // WAR and WAW on the destination
    war = req_i.use_vd ? id_bit(read_live[req_i.vd]) : '0;
    waw = req_i.use_vd ? id_bit(write_live[req_i.vd]) : '0;
  end

  // WAR applies to every operand port
  assign hazard_vs_o = raw_vs | war;
  assign hazard_vm_o = raw_vm | war;
  assign hazard_vd_o = waw;

  // Issued instruction becomes the latest accessor
  always_comb begin
    read_d  = read_live;
    write_d = write_live;
    if (issue_i) begin
      if (req_i.use_vd)
        write_d[req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs1)
        read_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs2)
        read_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      if (!req_i.vm)
        read_d[`VSEQ_VMASK] = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_q  <= '0;
      write_q <= '0;
    end else begin
      read_q  <= read_d;
      write_q <= write_d;
    end
  end

endmodule

`default_nettype wire

/* vseq.f */
+incdir+.
vseq_req_pkg.sv
vseq_pe_pkg.sv
vinsn_tracker.sv
vreg_scoreboard.sv
vseq_issue.sv
vseq_top.sv
tb_vseq.sv

/* vseq_issue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vseq_macros.svh"

module vseq_issue (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Dispatcher
  input  vseq_req_pkg::vseq_req_t                  req_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  output vseq_req_pkg::vseq_resp_t                 resp_o,
  output logic                                     resp_valid_o,
  // PE broadcast
  output vseq_pe_pkg::pe_req_t                     pe_req_o,
  output logic                                     pe_req_valid_o,
  input  logic                  [`VSEQ_NR_PES-1:0] pe_req_ready_i,
  // Lane 0 scalar result and address generator
  input  vseq_req_pkg::elen_t                      scalar_resp_i,
  input  logic                                     scalar_resp_valid_i,
  input  logic                                     addrgen_ack_i,
  input  logic                                     addrgen_error_i,
  // Tracker
  input  vseq_pe_pkg::vid_mask_t                   running_i,
  input  vseq_pe_pkg::vid_mask_t                   running_next_i,
  input  logic                  [`VSEQ_NR_PES-1:0] pe_busy_i,
  input  vseq_pe_pkg::vid_t                        next_id_i,
  input  logic                                     full_i,
  // Scoreboard
  input  vseq_pe_pkg::vid_mask_t                   hazard_vs_i,
  input  vseq_pe_pkg::vid_mask_t                   hazard_vd_i,
  input  vseq_pe_pkg::vid_mask_t                   hazard_vm_i,
  // Issue event
  output logic                                     issue_o,
  output vseq_pe_pkg::vid_t                        issue_id_o,
  output logic                  [`VSEQ_NR_PES-1:0] issue_pes_o
);

  // WAIT holds the dispatcher until the ack or the scalar result
  typedef enum logic {IDLE, WAIT} state_e;
  state_e state_q, state_d;

  vseq_req_pkg::vfu_e   req_vfu;
  logic                 needs_wait, struct_hazard, all_ready, held, wait_done, can_issue;
  vseq_pe_pkg::pe_req_t pe_req_d;
  logic                 pe_req_valid_d;

  function automatic vseq_req_pkg::vfu_e vfu_of(input vseq_req_pkg::vop_e op);
    case (op)
      vseq_req_pkg::VMAND: vfu_of = vseq_req_pkg::VFU_MASK;
      vseq_req_pkg::VLE:   vfu_of = vseq_req_pkg::VFU_LOAD;
      vseq_req_pkg::VSE:   vfu_of = vseq_req_pkg::VFU_STORE;
      default:             vfu_of = vseq_req_pkg::VFU_LANES;
    endcase
  endfunction

  assign req_vfu    = vfu_of(req_i.op);
  assign needs_wait = req_i.op inside {vseq_req_pkg::VLE, vseq_req_pkg::VSE, vseq_req_pkg::VMVXS};
  assign all_ready  = &pe_req_ready_i;
  // Broadcast still out and not taken by every PE
  assign held       = pe_req_valid_o && !all_ready;

  // Store and mask units share one queue
  assign struct_hazard =
      (req_vfu == vseq_req_pkg::VFU_STORE && pe_busy_i[`VSEQ_PE_MASK]) ||
      (req_vfu == vseq_req_pkg::VFU_MASK && pe_busy_i[`VSEQ_PE_STORE]);

  // Waiting op is still in the held broadcast
  assign wait_done = (state_q == WAIT) &&
      ((pe_req_o.op == vseq_req_pkg::VMVXS) ? scalar_resp_valid_i : addrgen_ack_i);

  // Release cycle may take the next request
  assign can_issue   = (state_q == IDLE || wait_done) && all_ready && !struct_hazard && !full_i;
  assign req_ready_o = can_issue;
  assign issue_o     = req_valid_i && can_issue;
  assign issue_id_o  = next_id_i;

  // Target PEs, plus the mask unit for masked ops
  always_comb begin
    issue_pes_o = '0;
    case (req_vfu)
      vseq_req_pkg::VFU_LOAD:  issue_pes_o[`VSEQ_PE_LOAD]  = 1'b1;
      vseq_req_pkg::VFU_STORE: issue_pes_o[`VSEQ_PE_STORE] = 1'b1;
      vseq_req_pkg::VFU_MASK:  issue_pes_o[`VSEQ_PE_MASK]  = 1'b1;
      default:                 issue_pes_o[`VSEQ_NR_LANES-1:0] = '1;
    endcase
    if (!req_i.vm)
      issue_pes_o[`VSEQ_PE_MASK] = 1'b1;
  end

  // Completion reply in the release cycle
  always_comb begin
    resp_o       = '0;
    resp_valid_o = wait_done;
    if (wait_done) begin
      if (pe_req_o.op == vseq_req_pkg::VMVXS)
        resp_o.resp = scalar_resp_i;
      else
        resp_o.error = addrgen_error_i;
    end
  end

  always_comb begin
    // Keep the last broadcast and drop finished IDs from it
    pe_req_d               = pe_req_o;
    pe_req_d.hazard_vs1    = pe_req_o.hazard_vs1 & running_next_i;
    pe_req_d.hazard_vs2    = pe_req_o.hazard_vs2 & running_next_i;
    pe_req_d.hazard_vd     = pe_req_o.hazard_vd & running_next_i;
    pe_req_d.hazard_vm     = pe_req_o.hazard_vm & running_next_i;
    pe_req_d.vinsn_running = pe_req_o.vinsn_running & running_next_i;
    pe_req_valid_d         = held;
    state_d                = wait_done ? IDLE : state_q;

    if (issue_o) begin
      pe_req_d.id            = next_id_i;
      pe_req_d.op            = req_i.op;
      pe_req_d.vfu           = req_vfu;
      pe_req_d.vs1           = req_i.vs1;
      pe_req_d.use_vs1       = req_i.use_vs1;
      pe_req_d.vs2           = req_i.vs2;
      pe_req_d.use_vs2       = req_i.use_vs2;
      pe_req_d.vd            = req_i.vd;
      pe_req_d.use_vd        = req_i.use_vd;
      pe_req_d.vm            = req_i.vm;
      pe_req_d.scalar_op     = req_i.scalar_op;
      // Finished IDs never reach the PEs
      pe_req_d.hazard_vs1    = hazard_vs_i & running_next_i;
      pe_req_d.hazard_vs2    = hazard_vs_i & running_next_i;
      pe_req_d.hazard_vd     = hazard_vd_i & running_next_i;
      pe_req_d.hazard_vm     = hazard_vm_i & running_next_i;
      // Other IDs still in flight, own ID excluded
      pe_req_d.vinsn_running = running_i & running_next_i;
      pe_req_valid_d         = 1'b1;
      if (needs_wait)
        state_d = WAIT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  // Broadcast payload
  always_ff @(posedge clk_i) begin
    pe_req_o <= pe_req_d;
  end

endmodule

`default_nettype wire

/* vseq_macros.svh */
`ifndef VSEQ_MACROS_SVH
`define VSEQ_MACROS_SVH

// Vector lanes
`define VSEQ_NR_LANES 2
// PEs are the lanes plus the load, store and mask units
`define VSEQ_NR_PES (`VSEQ_NR_LANES + 3)
// Instructions that can be in flight at once
`define VSEQ_NR_VINSN 8
// Architectural vector registers
`define VSEQ_NR_VREGS 32
// v0 holds the mask
`define VSEQ_VMASK 0
`define VSEQ_ELEN 32
// Unit PEs sit right after the lanes
`define VSEQ_PE_LOAD (`VSEQ_NR_LANES)
`define VSEQ_PE_STORE (`VSEQ_NR_LANES + 1)
`define VSEQ_PE_MASK (`VSEQ_NR_LANES + 2)

`endif

/* vseq_pe_pkg.sv */
`default_nettype none
`include "vseq_macros.svh"

package vseq_pe_pkg;

  // Instruction ID and one bit per ID
  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [`VSEQ_NR_VINSN-1:0] vid_mask_t;

  // Broadcast to every PE
  typedef struct packed {
    vid_t                id;
    vseq_req_pkg::vop_e  op;
    vseq_req_pkg::vfu_e  vfu;
    vseq_req_pkg::vreg_t vs1;
    logic                use_vs1;
    vseq_req_pkg::vreg_t vs2;
    logic                use_vs2;
    vseq_req_pkg::vreg_t vd;
    logic                use_vd;
    logic                vm;
    vseq_req_pkg::elen_t scalar_op;
    // IDs this instruction must wait for, per operand
    vid_mask_t           hazard_vs1;
    vid_mask_t           hazard_vs2;
    vid_mask_t           hazard_vd;
    vid_mask_t           hazard_vm;
    vid_mask_t           vinsn_running;
  } pe_req_t;

  // One done pulse per finished ID
  typedef struct packed {
    vid_mask_t vinsn_done;
  } pe_resp_t;

endpackage

`default_nettype wire

/* vseq_req_pkg.sv */
`default_nettype none
`include "vseq_macros.svh"

package vseq_req_pkg;

  // Register index and scalar word
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;
  typedef logic [`VSEQ_ELEN-1:0] elen_t;

  // Decoded operation from the dispatcher
  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VMAND,
    VLE,
    VSE,
    VMVXS
  } vop_e;

  // Unit that executes an operation
  typedef enum logic [1:0] {
    VFU_LANES,
    VFU_LOAD,
    VFU_STORE,
    VFU_MASK
  } vfu_e;

  typedef struct packed {
    vop_e  op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    // Set means unmasked
    logic  vm;
    elen_t scalar_op;
  } vseq_req_t;

  // Completion reply to the dispatcher
  typedef struct packed {
    elen_t resp;
    logic  error;
  } vseq_resp_t;

endpackage

`default_nettype wire

/* vseq_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vseq_macros.svh"

module vseq_top (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Dispatcher
  input  vseq_req_pkg::vseq_req_t                  req_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  output vseq_req_pkg::vseq_resp_t                 resp_o,
  output logic                                     resp_valid_o,
  output logic                                     idle_o,
  // PEs
  output vseq_pe_pkg::pe_req_t                     pe_req_o,
  output logic                                     pe_req_valid_o,
  input  logic                  [`VSEQ_NR_PES-1:0] pe_req_ready_i,
  input  vseq_pe_pkg::pe_resp_t [`VSEQ_NR_PES-1:0] pe_resp_i,
  input  vseq_req_pkg::elen_t                      scalar_resp_i,
  input  logic                                     scalar_resp_valid_i,
  // Address generator
  input  logic                                     addrgen_ack_i,
  input  logic                                     addrgen_error_i
);

  // Tracker state
  vseq_pe_pkg::vid_mask_t  running, running_next;
  logic [`VSEQ_NR_PES-1:0] pe_busy;
  vseq_pe_pkg::vid_t       next_id;
  logic                    full;
  // Issue event
  logic                    issue;
  vseq_pe_pkg::vid_t       issue_id;
  logic [`VSEQ_NR_PES-1:0] issue_pes;
  // Hazards of the presented request
  vseq_pe_pkg::vid_mask_t  hazard_vs, hazard_vd, hazard_vm;

  vinsn_tracker i_tracker (
    .clk_i, .rst_ni,
    .issue_i(issue), .issue_id_i(issue_id), .issue_pes_i(issue_pes), .pe_resp_i,
    .running_o(running), .running_next_o(running_next), .pe_busy_o(pe_busy),
    .next_id_o(next_id), .full_o(full), .idle_o
  );

  vreg_scoreboard i_scoreboard (
    .clk_i, .rst_ni, .req_i, .issue_i(issue), .issue_id_i(issue_id), .running_i(running),
    .hazard_vs_o(hazard_vs), .hazard_vd_o(hazard_vd), .hazard_vm_o(hazard_vm)
  );

  vseq_issue i_issue (
    .clk_i, .rst_ni, .req_i, .req_valid_i, .req_ready_o, .resp_o, .resp_valid_o,
    .pe_req_o, .pe_req_valid_o, .pe_req_ready_i,
    .scalar_resp_i, .scalar_resp_valid_i, .addrgen_ack_i, .addrgen_error_i,
    .running_i(running), .running_next_i(running_next), .pe_busy_i(pe_busy),
    .next_id_i(next_id), .full_i(full),
    .hazard_vs_i(hazard_vs), .hazard_vd_i(hazard_vd), .hazard_vm_i(hazard_vm),
    .issue_o(issue), .issue_id_o(issue_id), .issue_pes_o(issue_pes)
  );

endmodule

`default_nettype wire
